//--- source/nora_pkg.sv
/* shared memory map and types for the cpu bus core
   io page is fixed at 9Fxx, the banked window is A000..BFFF (window code 5) */
package nora_pkg;

    // one data byte on the cpu or memory bus
    typedef logic [7:0] byte_t;

    // cpu address word, decoded either as io page or as memory view
    typedef union packed {
        struct packed {
            logic [7:0] page;       // address bits 15..8
            logic [3:0] dev;        // device field
            logic [3:0] rsel;       // register within device
        } io;
        struct packed {
            logic [2:0]  window;    // 8k window number
            logic [12:0] offs;      // offset inside the window
        } mem;
    } cpu_addr_u;

    // io page and devices inside it
    localparam byte_t      IO_PAGE  = 8'h9F;
    localparam logic [3:0] DEV_VIA  = 4'd0;    // gpio slave
    localparam logic [3:0] DEV_SYS  = 4'd1;    // system regs
    localparam logic [3:0] DEV_VERA = 4'd2;    // external video chip

    // ram window at A000..BFFF, banked
    localparam logic [2:0] BANK_WINDOW = 3'd5;

    // only 128 banks visible after reset
    localparam byte_t BANK_MASK_RST = 8'h7F;

    // open bus value
    localparam byte_t UNMAPPED_DATA = 8'hFF;

    // memory high address covers bits 20..12
    localparam int MEM_AH_W = 9;

endpackage

//--- source/nora_slave_if.sv
/* one cpu bus cycle from the decoder to the internal slaves
   req lines are levels, wr_valid a single pulse, read data is combinational */
interface nora_slave_if import nora_pkg::*; ();

    logic [3:0] reg_addr;   // register field of latched address
    byte_t      data_wr;    // latched write data
    logic       wr_valid;   // write strobe, write cycles only
    logic       req_via;    // gpio slave selected
    logic       req_sys;    // system regs selected
    byte_t      via_rd;     // gpio read data
    byte_t      sys_rd;     // sysreg read data

    modport decoder (
        output reg_addr, data_wr, wr_valid, req_via, req_sys,
        input  via_rd, sys_rd
    );

    modport slave (
        input  reg_addr, data_wr, wr_valid, req_via, req_sys,
        output via_rd, sys_rd
    );

endinterface

//--- source/cpu_phaser.sv
/* CYCLE_LEN must be even and at least 6; phi2 high in the second half
   stopping happens only at a cycle boundary, so phi2 is never cut short */
module cpu_phaser #(
    parameter int CYCLE_LEN = 6             // clk6x cycles per cpu cycle
) (
    input  logic clk6x,
    input  logic arst_n_i,
    input  logic run_i,                     // low stops at the end of the cycle
    output logic phi2_o,                    // cpu clock
    output logic stopped_o,                 // counter parked at 0
    output logic setup_cs_o,                // latch address, open selects
    output logic release_wr_o,              // end write strobe
    output logic release_cs_o               // end of cycle
);

    localparam int CW = $clog2(CYCLE_LEN);
    localparam logic [CW-1:0] CNT_LAST  = CW'(CYCLE_LEN - 1);
    localparam logic [CW-1:0] CNT_HALF  = CW'(CYCLE_LEN / 2);
    localparam logic [CW-1:0] CNT_RELWR = CW'(CYCLE_LEN - 2);

    logic [CW-1:0] cnt;
    logic [CW-1:0] cnt_nxt;
    logic          hold;                    // parked at start of cycle

    assign hold = (cnt == '0) && !run_i;

    always_comb
    begin
        if (cnt == CNT_LAST)
            cnt_nxt = '0;                   // wrap, boundary
        else if (hold)
            cnt_nxt = cnt;
        else
            cnt_nxt = cnt + 1'b1;
    end

    // outputs registered from the next count, so they line up with cnt
    always_ff @(posedge clk6x or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            cnt          <= '0;
            phi2_o       <= 1'b0;
            stopped_o    <= 1'b0;
            setup_cs_o   <= 1'b0;
            release_wr_o <= 1'b0;
            release_cs_o <= 1'b0;
        end
        else
        begin
            cnt          <= cnt_nxt;
            phi2_o       <= (cnt_nxt >= CNT_HALF);     // second half
            stopped_o    <= hold;
            setup_cs_o   <= (cnt_nxt == CNT_HALF);     // at phi2 rise
            release_wr_o <= (cnt_nxt == CNT_RELWR);
            release_cs_o <= (cnt_nxt == CNT_LAST);
        end
    end

endmodule

//--- source/bus_decoder.sv
/* address, rwn and write data are sampled at setup_cs; selects hold until release_cs
   read data on cpu_data_o is only meaningful in the release_cs cycle */
module bus_decoder import nora_pkg::*; (
    input  logic                clk6x,
    input  logic                arst_n_i,
    input  logic                setup_cs_i,
    input  logic                release_wr_i,
    input  logic                release_cs_i,
    input  logic                phi2_i,
    input  cpu_addr_u           cpu_addr_i,
    input  logic                cpu_rwn_i,
    input  byte_t               cpu_data_i,
    output byte_t               cpu_data_o,
    output logic                cpu_data_oe_o,
    input  byte_t               bank_i,            // masked ram bank
    output logic [MEM_AH_W-1:0] mem_addr_hi_o,
    input  byte_t               mem_data_i,
    output byte_t               mem_data_o,
    output logic                sram_csn_o,
    output logic                mem_rdn_o,
    output logic                mem_wrn_o,
    output logic                vera_csn_o,
    nora_slave_if.decoder       slv
);

    logic                is_io;
    logic                dec_sram, dec_via, dec_sys, dec_vera;
    logic [MEM_AH_W-1:0] ah_dec;
    logic                sel_sram, sel_via, sel_sys, sel_vera;
    logic                rd_act, wr_act;   // external bus strobes
    logic                rwn_q;
    logic [3:0]          rsel_q;
    byte_t               wdata_q;
    logic [MEM_AH_W-1:0] ah_q;

    // io page view of the address
    assign is_io    = (cpu_addr_i.io.page == IO_PAGE);
    assign dec_via  = is_io && (cpu_addr_i.io.dev == DEV_VIA);
    assign dec_sys  = is_io && (cpu_addr_i.io.dev == DEV_SYS);
    assign dec_vera = is_io && (cpu_addr_i.io.dev == DEV_VERA);
    assign dec_sram = !is_io;               // other io devices: unmapped

    // memory view, banked window goes above 64k
    always_comb
    begin
        if (cpu_addr_i.mem.window == BANK_WINDOW)
            ah_dec = {1'b1, bank_i[6:0], cpu_addr_i.mem.offs[12]};
        else
            ah_dec = MEM_AH_W'({cpu_addr_i.mem.window, cpu_addr_i.mem.offs[12]});
    end

    always_ff @(posedge clk6x or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            sel_sram <= 1'b0;
            sel_via  <= 1'b0;
            sel_sys  <= 1'b0;
            sel_vera <= 1'b0;
            rd_act   <= 1'b0;
            wr_act   <= 1'b0;
        end
        else if (setup_cs_i)
        begin
            sel_sram <= dec_sram;
            sel_via  <= dec_via;
            sel_sys  <= dec_sys;
            sel_vera <= dec_vera;
            rd_act   <= cpu_rwn_i & (dec_sram | dec_vera);   // external targets only
            wr_act   <= ~cpu_rwn_i & (dec_sram | dec_vera);
        end
        else if (release_cs_i)
        begin
            sel_sram <= 1'b0;
            sel_via  <= 1'b0;
            sel_sys  <= 1'b0;
            sel_vera <= 1'b0;
            rd_act   <= 1'b0;
            wr_act   <= 1'b0;
        end
        else if (release_wr_i)
            wr_act <= 1'b0;                 // write hold before cs goes away
    end

    always_ff @(posedge clk6x)
    begin
        if (setup_cs_i)
        begin
            rwn_q   <= cpu_rwn_i;
            rsel_q  <= cpu_addr_i.io.rsel;
            wdata_q <= cpu_data_i;
            ah_q    <= ah_dec;              // bank sampled with the address
        end
    end

    assign sram_csn_o    = ~sel_sram;
    assign vera_csn_o    = ~sel_vera;
    assign mem_rdn_o     = ~rd_act;
    assign mem_wrn_o     = ~wr_act;
    assign mem_addr_hi_o = ah_q;
    assign mem_data_o    = wdata_q;

    // cpu drives the bus in phase 1 and on writes
    assign cpu_data_oe_o = phi2_i & cpu_rwn_i;

    assign slv.reg_addr = rsel_q;
    assign slv.data_wr  = wdata_q;
    assign slv.wr_valid = release_wr_i & ~rwn_q;
    assign slv.req_via  = sel_via;
    assign slv.req_sys  = sel_sys;

    // read data source for the selected target
    always_comb
    begin
        if (sel_sram)
            cpu_data_o = mem_data_i;
        else if (sel_via)
            cpu_data_o = slv.via_rd;
        else if (sel_sys)
            cpu_data_o = slv.sys_rd;
        else
            cpu_data_o = UNMAPPED_DATA;     // vera, unmapped, idle
    end

endmodule

//--- source/gpio_via.sv
/* two 8-bit gpio ports, register layout as a 65C22: ORB 0, ORA 1, DDRB 2, DDRA 3
   no timers, no handshake lines; registers 4..15 read FF and ignore writes */
module gpio_via import nora_pkg::*; (
    input  logic        clk6x,
    input  logic        arst_n_i,
    nora_slave_if.slave slv,
    input  byte_t       port_a_i,           // pin levels
    input  byte_t       port_b_i,
    output byte_t       port_a_o,           // output registers
    output byte_t       port_b_o,
    output byte_t       ddr_a_o,            // 1 = output
    output byte_t       ddr_b_o
);

    localparam logic [3:0] REG_ORB  = 4'd0;
    localparam logic [3:0] REG_ORA  = 4'd1;
    localparam logic [3:0] REG_DDRB = 4'd2;
    localparam logic [3:0] REG_DDRA = 4'd3;

    byte_t orb, ora;
    byte_t ddrb, ddra;

    // output bit where driven, pin level where input
    function automatic byte_t pin_mix(byte_t out_r, byte_t ddr, byte_t pins);
        return (out_r & ddr) | (pins & ~ddr);
    endfunction

    always_ff @(posedge clk6x or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            orb  <= '0;
            ora  <= '0;
            ddrb <= '0;                     // all inputs after reset
            ddra <= '0;
        end
        else if (slv.wr_valid && slv.req_via)
        begin
            case (slv.reg_addr)
                REG_ORB:  orb  <= slv.data_wr;
                REG_ORA:  ora  <= slv.data_wr;
                REG_DDRB: ddrb <= slv.data_wr;
                REG_DDRA: ddra <= slv.data_wr;
                default:  ;                 // unimplemented
            endcase
        end
    end

    always_comb
    begin
        case (slv.reg_addr)
            REG_ORB:  slv.via_rd = pin_mix(orb, ddrb, port_b_i);
            REG_ORA:  slv.via_rd = pin_mix(ora, ddra, port_a_i);
            REG_DDRB: slv.via_rd = ddrb;
            REG_DDRA: slv.via_rd = ddra;
            default:  slv.via_rd = 8'hFF;
        endcase
    end

    assign port_a_o = ora;
    assign port_b_o = orb;
    assign ddr_a_o  = ddra;
    assign ddr_b_o  = ddrb;

endmodule

//--- source/sys_regs.sv
/* ram bank (reg 0) and bank mask (reg 1); other registers read FF
   the bank output is already masked, bank bits outside the mask fold back */
module sys_regs import nora_pkg::*; (
    input  logic        clk6x,
    input  logic        arst_n_i,
    nora_slave_if.slave slv,
    output byte_t       bank_o              // masked ram bank
);

    localparam logic [3:0] REG_BANK = 4'd0;
    localparam logic [3:0] REG_MASK = 4'd1;

    byte_t bank_r;
    byte_t mask_r;

    always_ff @(posedge clk6x or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            bank_r <= '0;
            mask_r <= BANK_MASK_RST;        // 128 banks
        end
        else if (slv.wr_valid && slv.req_sys)
        begin
            case (slv.reg_addr)
                REG_BANK: bank_r <= slv.data_wr;
                REG_MASK: mask_r <= slv.data_wr;
                default:  ;
            endcase
        end
    end

    // raw register values read back
    always_comb
    begin
        case (slv.reg_addr)
            REG_BANK: slv.sys_rd = bank_r;
            REG_MASK: slv.sys_rd = mask_r;
            default:  slv.sys_rd = 8'hFF;
        endcase
    end

    assign bank_o = bank_r & mask_r;

endmodule

//--- source/nora_top.sv
/* cpu side bus core: phaser, decoder, gpio and system registers
   tristate pins are split into in/out/oe; clock and async reset come in directly */
module nora_top import nora_pkg::*; #(
    parameter int CYCLE_LEN = 6             // clk6x per cpu cycle, even, >= 6
) (
    input  logic                clk6x,
    input  logic                arst_n_i,
    input  logic                run_i,
    // cpu bus
    input  logic [15:0]         cpu_addr_i,
    input  logic                cpu_rwn_i,
    input  byte_t               cpu_data_i,
    output byte_t               cpu_data_o,
    output logic                cpu_data_oe_o,
    output logic                cpu_phi2_o,
    output logic                cpu_stopped_o,
    // memory bus
    output logic [MEM_AH_W-1:0] mem_addr_hi_o,
    input  byte_t               mem_data_i,
    output byte_t               mem_data_o,
    output logic                sram_csn_o,
    output logic                mem_rdn_o,
    output logic                mem_wrn_o,
    output logic                vera_csn_o,
    // gpio pins
    output byte_t               gpio_a_o,
    output byte_t               gpio_b_o,
    output byte_t               gpio_a_oe_o,
    output byte_t               gpio_b_oe_o,
    input  byte_t               gpio_a_i,
    input  byte_t               gpio_b_i
);

    logic  setup_cs, release_wr, release_cs;
    byte_t bank;

    nora_slave_if slv_bus ();

    cpu_phaser #(
        .CYCLE_LEN (CYCLE_LEN)
    ) i_cpu_phaser (
        .clk6x        (clk6x),
        .arst_n_i     (arst_n_i),
        .run_i        (run_i),
        .phi2_o       (cpu_phi2_o),
        .stopped_o    (cpu_stopped_o),
        .setup_cs_o   (setup_cs),
        .release_wr_o (release_wr),
        .release_cs_o (release_cs)
    );

    bus_decoder i_bus_decoder (
        .clk6x         (clk6x),
        .arst_n_i      (arst_n_i),
        .setup_cs_i    (setup_cs),
        .release_wr_i  (release_wr),
        .release_cs_i  (release_cs),
        .phi2_i        (cpu_phi2_o),
        .cpu_addr_i    (cpu_addr_i),
        .cpu_rwn_i     (cpu_rwn_i),
        .cpu_data_i    (cpu_data_i),
        .cpu_data_o    (cpu_data_o),
        .cpu_data_oe_o (cpu_data_oe_o),
        .bank_i        (bank),
        .mem_addr_hi_o (mem_addr_hi_o),
        .mem_data_i    (mem_data_i),
        .mem_data_o    (mem_data_o),
        .sram_csn_o    (sram_csn_o),
        .mem_rdn_o     (mem_rdn_o),
        .mem_wrn_o     (mem_wrn_o),
        .vera_csn_o    (vera_csn_o),
        .slv           (slv_bus.decoder)
    );

    gpio_via i_gpio_via (
        .clk6x    (clk6x),
        .arst_n_i (arst_n_i),
        .slv      (slv_bus.slave),
        .port_a_i (gpio_a_i),
        .port_b_i (gpio_b_i),
        .port_a_o (gpio_a_o),
        .port_b_o (gpio_b_o),
        .ddr_a_o  (gpio_a_oe_o),            // direction doubles as pin oe
        .ddr_b_o  (gpio_b_oe_o)
    );

    sys_regs i_sys_regs (
        .clk6x    (clk6x),
        .arst_n_i (arst_n_i),
        .slv      (slv_bus.slave),
        .bank_o   (bank)
    );

endmodule

//--- verif/tb_clock.sv
/* free running testbench clock, reset held low for RST_CYCLES rising edges
   reset release lands 1 time unit after an edge */
module tb_clock #(
    parameter int PERIOD     = 4,
    parameter int RST_CYCLES = 16
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial
    begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    initial
    begin
        arst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1 arst_n_o = 1'b1;                 // off the edge
    end

endmodule

//--- verif/tb_nora.sv
/* trace driven testbench, one cpu bus cycle per trace record
   "xx" in the trace stands for the last generated random byte */
module tb_nora import nora_pkg::*; ();

    localparam int CYCLE_LEN = 6;
    localparam int MAX_REC   = 64;

    logic                clk6x, arst_n, run;
    logic [15:0]         cpu_addr;
    logic                cpu_rwn, cpu_data_oe, phi2, stopped;
    byte_t               cpu_data_in, cpu_data_out, mem_data_in, mem_data_out;
    logic [MEM_AH_W-1:0] mem_ah;
    logic                sram_csn, mem_rdn, mem_wrn, vera_csn;
    byte_t               gpio_a, gpio_b, gpio_a_oe, gpio_b_oe, pins_a, pins_b;

    // trace columns
    logic [127:0]        t_name [MAX_REC];
    logic                t_rwn  [MAX_REC];
    logic [15:0]         t_addr [MAX_REC];
    byte_t               t_data [MAX_REC], t_pa [MAX_REC], t_pb [MAX_REC];
    byte_t               t_rd   [MAX_REC];
    logic [MEM_AH_W-1:0] t_ah   [MAX_REC];
    logic [4:0]          t_sel  [MAX_REC];
    byte_t               t_ao [MAX_REC], t_aoe [MAX_REC], t_bo [MAX_REC], t_boe [MAX_REC];

    int          n_rec = 0;
    int          errors = 0, test_errs = 0, tests_run = 0, tests_failed = 0;
    int          cycles = 0, limit = 0;
    logic [31:0] rng_state = 32'd9113;
    byte_t       last_rand = '0;

    tb_clock #(.PERIOD(4), .RST_CYCLES(16)) i_tb_clock (.clk_o(clk6x), .arst_n_o(arst_n));

    nora_top #(.CYCLE_LEN(CYCLE_LEN)) i_nora_top (
        .clk6x (clk6x), .arst_n_i (arst_n), .run_i (run),
        .cpu_addr_i (cpu_addr), .cpu_rwn_i (cpu_rwn), .cpu_data_i (cpu_data_in),
        .cpu_data_o (cpu_data_out), .cpu_data_oe_o (cpu_data_oe),
        .cpu_phi2_o (phi2), .cpu_stopped_o (stopped),
        .mem_addr_hi_o (mem_ah), .mem_data_i (mem_data_in), .mem_data_o (mem_data_out),
        .sram_csn_o (sram_csn), .mem_rdn_o (mem_rdn), .mem_wrn_o (mem_wrn),
        .vera_csn_o (vera_csn),
        .gpio_a_o (gpio_a), .gpio_b_o (gpio_b), .gpio_a_oe_o (gpio_a_oe),
        .gpio_b_oe_o (gpio_b_oe), .gpio_a_i (pins_a), .gpio_b_i (pins_b)
    );

    // 32 bit xorshift, low byte used
    function automatic byte_t xorshift_next();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state[7:0];
    endfunction

    // wildcard trace value means last random byte
    function automatic byte_t resolve(byte_t v);
        return $isunknown(v) ? last_rand : v;
    endfunction

    task automatic check_byte(input logic [127:0] name, input string what,
                              input byte_t exp, input byte_t act);
        if (act !== exp)
        begin
            $display("[FAIL] %0s %0s expected %02h actual %02h", name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_addr_hi(input logic [127:0] name, input logic [MEM_AH_W-1:0] exp,
                                 input logic [MEM_AH_W-1:0] act);
        if (act !== exp)
        begin
            $display("[FAIL] %0s addr_hi expected %03h actual %03h", name, exp, act);
            test_errs++;
        end
    endtask

    // select code {oe, sram, vera, rd, wr}, all active high
    task automatic check_sel(input logic [127:0] name, input logic [4:0] exp,
                             input logic [4:0] act);
        if (act !== exp)
        begin
            $display("[FAIL] %0s select expected %b actual %b", name, exp, act);
            test_errs++;
        end
    endtask

    task automatic finish_test(input logic [127:0] name);
        tests_run++;
        if (test_errs != 0)
            tests_failed++;
        $display("test %0s: %0s", name, (test_errs == 0) ? "ok" : "errors");
        errors += test_errs;
        test_errs = 0;
    endtask

    task automatic load_trace();
        int    fd, cnt;
        string line;
        logic [127:0] nm;
        logic  rw;
        logic [15:0] ad;
        byte_t d, pa, pb, rd, ao, aoe, bo, boe;
        logic [MEM_AH_W-1:0] ah;
        logic [4:0] sel;
        fd = $fopen("verif/nora_trace.txt", "r");
        if (fd != 0)
        begin
            while (!$feof(fd) && n_rec < MAX_REC)
            begin
                line = "";
                cnt = $fgets(line, fd);
                if (cnt > 1 && line.getc(0) != "#")
                begin
                    cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h",
                                  nm, rw, ad, d, pa, pb, rd, ah, sel, ao, aoe, bo, boe);
                    if (cnt == 13)
                    begin
                        t_name[n_rec] = nm;
                        t_rwn[n_rec]  = rw;
                        t_addr[n_rec] = ad;
                        t_data[n_rec] = d;
                        t_pa[n_rec]   = pa;
                        t_pb[n_rec]   = pb;
                        t_rd[n_rec]   = rd;
                        t_ah[n_rec]   = ah;
                        t_sel[n_rec]  = sel;
                        t_ao[n_rec]   = ao;
                        t_aoe[n_rec]  = aoe;
                        t_bo[n_rec]   = bo;
                        t_boe[n_rec]  = boe;
                        n_rec++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // one cpu cycle: drive in phase 1, selects at count 4, data at count 5
    task automatic run_record(input int i);
        byte_t wd;
        @(negedge phi2);
        #1;
        wd = t_data[i];
        if ($isunknown(wd))
        begin
            last_rand = xorshift_next();
            wd = last_rand;
        end
        cpu_addr    = t_addr[i];
        cpu_rwn     = t_rwn[i];
        cpu_data_in = wd;
        mem_data_in = wd;                   // sram read data on reads
        pins_a      = t_pa[i];
        pins_b      = t_pb[i];
        @(posedge phi2);
        @(posedge clk6x);
        #1;
        check_sel(t_name[i], t_sel[i], {cpu_data_oe, ~sram_csn, ~vera_csn, ~mem_rdn, ~mem_wrn});
        check_addr_hi(t_name[i], t_ah[i], mem_ah);
        if (t_sel[i][0])
            check_byte(t_name[i], "mem_data", wd, mem_data_out);
        @(posedge clk6x);
        #1;
        if (t_rwn[i])
            check_byte(t_name[i], "read", resolve(t_rd[i]), cpu_data_out);
        check_byte(t_name[i], "gpio_a", resolve(t_ao[i]), gpio_a);
        check_byte(t_name[i], "gpio_a_oe", resolve(t_aoe[i]), gpio_a_oe);
        check_byte(t_name[i], "gpio_b", resolve(t_bo[i]), gpio_b);
        check_byte(t_name[i], "gpio_b_oe", resolve(t_boe[i]), gpio_b_oe);
        finish_test(t_name[i]);
    endtask

    task automatic idle_check(input logic [127:0] name);
        if (!sram_csn || !vera_csn || !mem_rdn || !mem_wrn || cpu_data_oe)
        begin
            $display("%0s: a select, strobe or output enable is active while idle", name);
            test_errs++;
        end
    endtask

    task automatic stop_test();
        int k;
        @(negedge phi2);
        #1 run = 1'b0;
        k = 0;
        while (!stopped && k < 2 * CYCLE_LEN)
        begin
            @(posedge clk6x);
            #1 k++;
        end
        if (!stopped)
        begin
            $display("stop_resume: stopped output never went high");
            test_errs++;
        end
        repeat (3 * CYCLE_LEN)
        begin
            @(posedge clk6x);
            #1;
            if (phi2 || !stopped)
            begin
                $display("stop_resume: phi2 ran or stopped dropped while run is low");
                test_errs++;
            end
        end
        run = 1'b1;
        k = 0;
        while (!phi2 && k < 2 * CYCLE_LEN)
        begin
            @(posedge clk6x);
            #1 k++;
        end
        if (!phi2 || stopped)
        begin
            $display("stop_resume: phi2 did not restart or stopped stayed high after run");
            test_errs++;
        end
        finish_test("stop_resume");
    endtask

    // watchdog, limit set once the trace length is known
    always @(posedge clk6x)
    begin
        cycles++;
        if (limit != 0 && cycles > limit)
        begin
            $display("timeout after %0d cycles, the DUT stopped making bus cycles", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial
    begin
        run         = 1'b1;
        cpu_addr    = '0;
        cpu_rwn     = 1'b1;
        cpu_data_in = '0;
        mem_data_in = '0;
        pins_a      = '0;
        pins_b      = '0;
        load_trace();
        limit = (n_rec + 2) * CYCLE_LEN * 4 + 16;
        if (n_rec == 0)
        begin
            $display("trace file could not be read or holds no records");
            errors++;
        end
        else
        begin
            repeat (2) @(posedge clk6x);
            #1;
            idle_check("reset_idle");
            if (phi2)
            begin
                $display("reset_idle: phi2 high during reset");
                test_errs++;
            end
            @(posedge arst_n);
            @(posedge clk6x);
            #1 idle_check("reset_idle");
            @(posedge phi2);                // first clock edge seen
            finish_test("reset_idle");
            for (int i = 0; i < n_rec; i++)
                run_record(i);
            stop_test();
        end
        $display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- verif/nora_trace.txt
# name rwn addr data pa pb exp_rd exp_ah exp_sel gpio_a gpio_a_oe gpio_b gpio_b_oe
# sel bits {oe,sram,vera,rd,wr}; data is write data or sram read data; xx = random byte
rst_mask   1 9F11 00 00 00 7F 009 10 00 00 00 00
rst_bank   1 9F10 00 00 00 00 009 10 00 00 00 00
sram_rd_lo 1 1234 5A 00 00 5A 001 1A 00 00 00 00
sram_wr_lo 0 7ABC C3 00 00 00 007 09 00 00 00 00
sram_rd_hi 1 F000 96 00 00 96 00F 1A 00 00 00 00
sram_rd_c  1 C123 3C 00 00 3C 00C 1A 00 00 00 00
bank_wr    0 9F10 03 00 00 00 009 00 00 00 00 00
win_lo     1 A000 11 00 00 11 106 1A 00 00 00 00
win_hi_wr  0 B800 22 00 00 00 107 09 00 00 00 00
bank_fold  0 9F10 83 00 00 00 009 00 00 00 00 00
bank_rd    1 9F10 00 00 00 83 009 10 00 00 00 00
win_fold   1 A5A5 44 00 00 44 106 1A 00 00 00 00
mask_wr    0 9F11 0F 00 00 00 009 00 00 00 00 00
mask_rd    1 9F11 00 00 00 0F 009 10 00 00 00 00
win_mask   1 BFFF 55 00 00 55 107 1A 00 00 00 00
mask_back  0 9F11 7F 00 00 00 009 00 00 00 00 00
ddra_wr    0 9F03 F0 00 00 00 009 00 00 F0 00 00
ora_wr     0 9F01 A5 00 00 00 009 00 A5 F0 00 00
ddrb_wr    0 9F02 0F 00 00 00 009 00 A5 F0 00 0F
orb_wr     0 9F00 3C 00 00 00 009 00 A5 F0 3C 0F
ora_rd     1 9F01 00 5A 00 AA 009 10 A5 F0 3C 0F
orb_rd     1 9F00 00 00 C3 CC 009 10 A5 F0 3C 0F
ddra_rd    1 9F03 00 00 00 F0 009 10 A5 F0 3C 0F
via_hi_rd  1 9F0C 00 00 00 FF 009 10 A5 F0 3C 0F
via_hi_wr  0 9F0C 12 00 00 00 009 00 A5 F0 3C 0F
ddra_all   0 9F03 FF 00 00 00 009 00 A5 FF 3C 0F
rnd_wr     0 9F01 xx 00 00 00 009 00 xx FF 3C 0F
rnd_rd     1 9F01 00 00 00 xx 009 10 xx FF 3C 0F
rnd_wr2    0 9F01 xx 00 00 00 009 00 xx FF 3C 0F
rnd_rd2    1 9F01 00 00 00 xx 009 10 xx FF 3C 0F
vera_rd    1 9F20 00 00 00 FF 009 16 xx FF 3C 0F
vera_wr    0 9F2A 77 00 00 00 009 05 xx FF 3C 0F
unmap_rd   1 9F70 00 00 00 FF 009 10 xx FF 3C 0F

//--- verilog.f
source/nora_pkg.sv
source/nora_slave_if.sv
source/cpu_phaser.sv
source/bus_decoder.sv
source/gpio_via.sv
source/sys_regs.sv
source/nora_top.sv
verif/tb_clock.sv
verif/tb_nora.sv
